/* verilog/ball_game_config.svh */
`ifndef BALL_GAME_CONFIG_SVH
`define BALL_GAME_CONFIG_SVH

// Motion step rate.
`define BALL_STEP_DIV 2 // Clocks per motion step.

// Coordinate width shared by X and Y.
`define BALL_COORD_W 10

// Horizontal playfield limits.
`define BALL_X_MIN 0
`define BALL_X_MAX 639

// Start position after reset.
`define BALL_X_START 320 // Screen centre.
`define BALL_GROUND_Y 400 // Resting height, also the lowest Y.

// Horizontal speed.
`define BALL_X_STEP 2 // Pixels per step.

`endif

/* verilog/ball_game_pkg.sv */
`include "ball_game_config.svh"

package ball_game_pkg;

	// Unsigned screen coordinate.
	typedef logic [`BALL_COORD_W-1:0] coord_t;

	// Signed vertical speed, pixels per step.
	typedef logic signed [`BALL_COORD_W-1:0] velocity_t;

	// Ball position, x in the upper half.
	typedef struct packed
	{
		coord_t x;
		coord_t y;
	} ball_pos_t;

	// Player key levels.
	typedef struct packed
	{
		logic jump;
		logic left;
		logic right;
	} ball_keys_t;

endpackage

/* verilog/motion_step_gen.sv */
`timescale 1ns/1ns
`include "ball_game_config.svh"

module motion_step_gen
(
	input logic clk,
	input logic Reset,
	output logic step
);

	localparam int CNT_W = (`BALL_STEP_DIV > 1) ? $clog2(`BALL_STEP_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`BALL_STEP_DIV - 1);

	logic [CNT_W-1:0] cnt;

	// Down-counter, step fires as it wraps.
	always_ff @(posedge clk or posedge Reset)
	begin
		if (Reset)
		begin
			cnt <= CNT_LOAD;
			step <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt <= CNT_LOAD; // Reload for next period.
			step <= 1'b1;
		end
		else
		begin
			cnt <= cnt - 1'b1;
			step <= 1'b0;
		end
	end

	// A strobe lasts one clock whenever the divider is above one.
	a_step_single: assert property (@(posedge clk) disable iff (Reset)
		((`BALL_STEP_DIV > 1) && step) |=> !step);

endmodule

/* verilog/jump_control.sv */
`timescale 1ns/1ns

module jump_control
(
	input logic clk,
	input logic Reset,
	input logic step,
	input logic jump,
	output ball_game_pkg::velocity_t y_velocity,
	output logic airborne
);

	// Rest, rise, apex, fall and settle tail.
	typedef enum logic [5:0]
	{
		st_rest,
		st_up8_0, st_up8_1,
		st_up6_0, st_up6_1, st_up6_2, st_up6_3,
		st_up5_0, st_up5_1,
		st_up4_0, st_up4_1,
		st_up3_0, st_up3_1,
		st_up2_0, st_up2_1,
		st_apex_0, st_apex_1,
		st_dn2_0, st_dn2_1,
		st_dn3_0, st_dn3_1,
		st_dn4_0, st_dn4_1,
		st_dn5_0, st_dn5_1,
		st_dn6_0, st_dn6_1, st_dn6_2, st_dn6_3,
		st_dn8_0, st_dn8_1,
		st_settle_0, st_settle_1, st_settle_2,
		st_settle_3, st_settle_4, st_settle_5
	} jump_state_t;

	jump_state_t state, state_next;

	always_ff @(posedge clk or posedge Reset)
	begin
		if (Reset)
			state <= st_rest;
		else if (step)
			state <= state_next; // One table entry per step.
	end

	always_comb
	begin
		state_next = state;
		case (state)
			st_rest: if (jump) state_next = st_up8_0;
			st_up8_0: state_next = st_up8_1;
			st_up8_1: state_next = st_up6_0;
			st_up6_0: state_next = st_up6_1;
			st_up6_1: state_next = st_up6_2;
			st_up6_2: state_next = st_up6_3;
			st_up6_3: state_next = st_up5_0;
			st_up5_0: state_next = st_up5_1;
			st_up5_1: state_next = st_up4_0;
			st_up4_0: state_next = st_up4_1;
			st_up4_1: state_next = st_up3_0;
			st_up3_0: state_next = st_up3_1;
			st_up3_1: state_next = st_up2_0;
			st_up2_0: state_next = st_up2_1;
			st_up2_1: state_next = st_apex_0;
			st_apex_0: state_next = st_apex_1;
			st_apex_1: state_next = st_dn2_0;
			st_dn2_0: state_next = st_dn2_1;
			st_dn2_1: state_next = st_dn3_0;
			st_dn3_0: state_next = st_dn3_1;
			st_dn3_1: state_next = st_dn4_0;
			st_dn4_0: state_next = st_dn4_1;
			st_dn4_1: state_next = st_dn5_0;
			st_dn5_0: state_next = st_dn5_1;
			st_dn5_1: state_next = st_dn6_0;
			st_dn6_0: state_next = st_dn6_1;
			st_dn6_1: state_next = st_dn6_2;
			st_dn6_2: state_next = st_dn6_3;
			st_dn6_3: state_next = st_dn8_0;
			st_dn8_0: state_next = st_dn8_1;
			st_dn8_1: state_next = st_settle_0;
			st_settle_0: state_next = st_settle_1;
			st_settle_1: state_next = st_settle_2;
			st_settle_2: state_next = st_settle_3;
			st_settle_3: state_next = st_settle_4;
			st_settle_4: state_next = st_settle_5;
			st_settle_5: state_next = st_rest; // Back on the ground.
			default: state_next = st_rest;
		endcase
	end

	// Velocity table, 68 pixels up and 68 down.
	always_comb
	begin
		case (state)
			st_up8_0, st_up8_1: y_velocity = -8;
			st_up6_0, st_up6_1, st_up6_2, st_up6_3: y_velocity = -6;
			st_up5_0, st_up5_1: y_velocity = -5;
			st_up4_0, st_up4_1: y_velocity = -4;
			st_up3_0, st_up3_1: y_velocity = -3;
			st_up2_0, st_up2_1: y_velocity = -2;
			st_dn2_0, st_dn2_1: y_velocity = 2;
			st_dn3_0, st_dn3_1: y_velocity = 3;
			st_dn4_0, st_dn4_1: y_velocity = 4;
			st_dn5_0, st_dn5_1: y_velocity = 5;
			st_dn6_0, st_dn6_1, st_dn6_2, st_dn6_3: y_velocity = 6;
			st_dn8_0, st_dn8_1: y_velocity = 8;
			default: y_velocity = '0; // Rest, apex and settle.
		endcase
	end

	assign airborne = (state != st_rest);

	// Resting ball must not drift.
	a_rest_still: assert property (@(posedge clk) disable iff (Reset)
		(state == st_rest) |-> (y_velocity == '0));

	// A jump starts only from a sampled key.
	a_rest_hold: assert property (@(posedge clk) disable iff (Reset)
		((state == st_rest) && step && !jump) |=> (state == st_rest));

endmodule

/* verilog/ball_motion.sv */
`timescale 1ns/1ns
`include "ball_game_config.svh"

module ball_motion
(
	input logic clk,
	input logic Reset,
	input logic step,
	input ball_game_pkg::velocity_t y_velocity,
	input logic left,
	input logic right,
	output ball_game_pkg::ball_pos_t ball_pos
);

	import ball_game_pkg::*;

	localparam coord_t X_MIN = coord_t'(`BALL_X_MIN);
	localparam coord_t X_MAX = coord_t'(`BALL_X_MAX);
	localparam coord_t X_STEP = coord_t'(`BALL_X_STEP);
	localparam coord_t X_START = coord_t'(`BALL_X_START);
	localparam coord_t GROUND_Y = coord_t'(`BALL_GROUND_Y);

	logic move_left;
	logic move_right;
	coord_t x_next;
	coord_t y_next;

	// Opposite keys cancel.
	assign move_left = left && !right;
	assign move_right = right && !left;

	// Horizontal step with saturation at the walls.
	always_comb
	begin
		x_next = ball_pos.x;
		if (move_right)
		begin
			if (ball_pos.x > X_MAX - X_STEP)
				x_next = X_MAX;
			else
				x_next = ball_pos.x + X_STEP;
		end
		else if (move_left)
		begin
			if (ball_pos.x < X_MIN + X_STEP)
				x_next = X_MIN; // Keeps clear of underflow.
			else
				x_next = ball_pos.x - X_STEP;
		end
	end

	// Two's complement add, negative speed moves up.
	assign y_next = ball_pos.y + coord_t'(y_velocity);

	always_ff @(posedge clk or posedge Reset)
	begin
		if (Reset)
		begin
			ball_pos.x <= X_START;
			ball_pos.y <= GROUND_Y;
		end
		else if (step)
		begin
			ball_pos.x <= x_next;
			ball_pos.y <= y_next;
		end
	end

	// The velocity table must sum to zero so the ball lands on the ground.
	a_above_ground: assert property (@(posedge clk) disable iff (Reset)
		ball_pos.y <= GROUND_Y);

endmodule

/* verilog/ball_game_top.sv */
`timescale 1ns/1ns

module ball_game_top
(
	input logic clk,
	input logic Reset,
	input ball_game_pkg::ball_keys_t keys,
	output ball_game_pkg::ball_pos_t ball_pos,
	output logic airborne,
	output logic step
);

	import ball_game_pkg::*;

	velocity_t y_velocity;

	motion_step_gen i_motion_step_gen
	(
		.clk (clk),
		.Reset (Reset),
		.step (step)
	);

	jump_control i_jump_control
	(
		.clk (clk),
		.Reset (Reset),
		.step (step),
		.jump (keys.jump),
		.y_velocity (y_velocity),
		.airborne (airborne)
	);

	// Position seen one step after the velocity.
	ball_motion i_ball_motion
	(
		.clk (clk),
		.Reset (Reset),
		.step (step),
		.y_velocity (y_velocity),
		.left (keys.left),
		.right (keys.right),
		.ball_pos (ball_pos)
	);

endmodule

/* sim/tb_ball_game.sv */
`timescale 1ns/1ns
`include "ball_game_config.svh"

module tb_ball_game;

	import ball_game_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int X_MIN = `BALL_X_MIN;
	localparam int X_MAX = `BALL_X_MAX;
	localparam int X_STEP = `BALL_X_STEP;
	localparam int X_START = `BALL_X_START;
	localparam int GROUND_Y = `BALL_GROUND_Y;
	localparam int ARC_LEN = 36;
	localparam int STEP_WAIT_MAX = 2 * `BALL_STEP_DIV;

	// Steps per test, the clamp test walks wall to wall.
	localparam int STEPS_T1 = 10;
	localparam int STEPS_T2 = 38;
	localparam int STEPS_T3 = 74;
	localparam int STEPS_T4 = 487;
	localparam int STEPS_T5 = 300;
	localparam int TOTAL_STEPS = STEPS_T1 + STEPS_T2 + STEPS_T3 + STEPS_T4 + STEPS_T5;
	localparam int WATCHDOG_NS = (TOTAL_STEPS + 100) * `BALL_STEP_DIV * CLK_PERIOD;

	logic clk = 1'b0;
	logic Reset;
	ball_keys_t keys;
	ball_pos_t ball_pos;
	logic airborne;
	logic step;

	// Reference jump profile, pixels per step.
	int vel_table [0:ARC_LEN-1] = '{
		-8, -8, -6, -6, -6, -6, -5, -5, -4, -4, -3, -3, -2, -2, 0, 0, 2, 2,
		3, 3, 4, 4, 5, 5, 6, 6, 6, 6, 8, 8, 0, 0, 0, 0, 0, 0};

	int model_x;
	int model_y;
	int model_state; // 0 is rest, k is table entry k-1.
	integer seed = 32'h5624_ed31;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	int test_errors_start;
	string test_name;

	ball_game_top i_ball_game_top
	(
		.clk (clk),
		.Reset (Reset),
		.keys (keys),
		.ball_pos (ball_pos),
		.airborne (airborne),
		.step (step)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input int expected, input int actual);
		check_count++;
		assert (expected == actual)
		else
		begin
			$display("ERR %s expected %0h actual %0h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic start_test(input string name);
		test_count++;
		test_name = name;
		test_errors_start = error_count;
	endtask

	task automatic finish_test();
		if (error_count == test_errors_start)
			$display("test %0d %s: passed", test_count, test_name);
		else
			$display("test %0d %s: %0d errors", test_count, test_name,
				error_count - test_errors_start);
	endtask

	// One step of the reference model with the keys seen on that step.
	task automatic update_model(input ball_keys_t k);
		int v;
		v = (model_state == 0) ? 0 : vel_table[model_state-1];
		model_y = model_y + v;
		if (k.right && !k.left)
			model_x = (model_x + X_STEP > X_MAX) ? X_MAX : model_x + X_STEP;
		else if (k.left && !k.right)
			model_x = (model_x - X_STEP < X_MIN) ? X_MIN : model_x - X_STEP;
		if (model_state == 0)
			model_state = k.jump ? 1 : 0;
		else if (model_state == ARC_LEN)
			model_state = 0;
		else
			model_state++;
	endtask

	// Called on a falling edge, returns on the falling edge after the update.
	task automatic advance_step();
		int waited;
		waited = 0;
		while (!step && waited < STEP_WAIT_MAX)
		begin
			@(negedge clk);
			waited++;
		end
		assert (step)
		else
		begin
			$display("no step strobe arrived within %0d clocks", STEP_WAIT_MAX);
			error_count++;
		end
		@(negedge clk);
		if (`BALL_STEP_DIV > 1)
			check_value("step", 0, step); // Strobe is one clock wide.
	endtask

	task automatic step_and_compare();
		update_model(keys);
		advance_step();
		check_value("ball_pos.x", model_x, ball_pos.x);
		check_value("ball_pos.y", model_y, ball_pos.y);
		check_value("airborne", (model_state != 0), airborne);
	endtask

	task automatic check_reset_state();
		start_test("reset state");
		Reset = 1'b1;
		keys = '0;
		repeat (5) @(negedge clk);
		check_value("step", 0, step); // Held low in reset.
		Reset = 1'b0;
		model_x = X_START;
		model_y = GROUND_Y;
		model_state = 0;
		check_value("ball_pos.x", X_START, ball_pos.x);
		check_value("ball_pos.y", GROUND_Y, ball_pos.y);
		check_value("airborne", 0, airborne);
		repeat (STEPS_T1) step_and_compare();
		finish_test();
	endtask

	task automatic single_jump_arc();
		int run_sum;
		int air_steps;
		int min_y;
		start_test("single jump trajectory");
		run_sum = 0;
		min_y = GROUND_Y;
		keys = '0;
		keys.jump = 1'b1;
		step_and_compare();
		keys.jump = 1'b0;
		air_steps = airborne ? 1 : 0;
		for (int i = 0; i < ARC_LEN; i++)
		begin
			step_and_compare();
			run_sum += vel_table[i];
			check_value("ball_pos.y", GROUND_Y + run_sum, ball_pos.y);
			if (airborne)
				air_steps++;
			if (ball_pos.y < min_y)
				min_y = ball_pos.y;
		end
		check_value("airborne step count", ARC_LEN, air_steps);
		check_value("top of arc ball_pos.y", 332, min_y);
		check_value("ball_pos.y", GROUND_Y, ball_pos.y);
		step_and_compare(); // Still at rest.
		finish_test();
	endtask

	task automatic jump_lockout_retrigger();
		int rest_steps;
		int air_steps;
		start_test("jump while airborne and held jump");
		keys = '0;
		keys.jump = 1'b1;
		step_and_compare();
		keys.jump = 1'b0;
		repeat (9) step_and_compare();
		keys.jump = 1'b1; // Pressed mid-arc, then held.
		rest_steps = 0;
		repeat (28)
		begin
			step_and_compare();
			if (!airborne)
				rest_steps++;
		end
		check_value("rest steps between arcs", 1, rest_steps);
		check_value("airborne", 1, airborne);
		keys.jump = 1'b0;
		air_steps = 1;
		repeat (ARC_LEN)
		begin
			step_and_compare();
			if (airborne)
				air_steps++;
		end
		check_value("airborne step count", ARC_LEN, air_steps);
		check_value("ball_pos.y", GROUND_Y, ball_pos.y);
		finish_test();
	endtask

	task automatic horizontal_clamp();
		int hold_x;
		start_test("horizontal movement and clamping");
		keys = '0;
		keys.right = 1'b1;
		while (model_x != X_MAX)
			step_and_compare();
		step_and_compare(); // Pushing into the wall.
		keys.right = 1'b0;
		keys.left = 1'b1;
		while (model_x != X_MIN)
			step_and_compare();
		step_and_compare();
		keys.right = 1'b1;
		hold_x = model_x;
		repeat (5)
		begin
			step_and_compare();
			check_value("ball_pos.x", hold_x, ball_pos.x);
		end
		keys = '0;
		finish_test();
	endtask

	task automatic random_key_soak();
		logic [31:0] rnd;
		start_test("random keys");
		for (int i = 0; i < STEPS_T5; i++)
		begin
			rnd = $random(seed);
			keys = ball_keys_t'(rnd[2:0]);
			step_and_compare();
		end
		keys = '0;
		finish_test();
	endtask

	initial
	begin
		Reset = 1'b1;
		keys = '0;
		check_reset_state();
		single_jump_arc();
		jump_lockout_retrigger();
		horizontal_clamp();
		random_key_soak();
		$display("summary: %0d tests, %0d checks, %0d errors",
			test_count, check_count, error_count);
		if (error_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Bounded by the step count of all tests plus margin.
	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("TB FAILED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+verilog
verilog/ball_game_pkg.sv
verilog/motion_step_gen.sv
verilog/jump_control.sv
verilog/ball_motion.sv
verilog/ball_game_top.sv
sim/tb_ball_game.sv

/* Bender.yml */
package:
  name: ball_game

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ball_game_pkg.sv
      - verilog/motion_step_gen.sv
      - verilog/jump_control.sv
      - verilog/ball_motion.sv
      - verilog/ball_game_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/tb_ball_game.sv
